//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   // Instruction word and byte address
   typedef logic [15:0] instr_t;
   typedef logic [15:0] pc_t;
   typedef logic [2:0]  reg_idx_t;

   //////////////////////////////////////////////////
   // Field positions
   //////////////////////////////////////////////////
   localparam int OPC_MSB = 15;
   localparam int RS_LSB  = 8;
   localparam int RT_LSB  = 5;
   localparam int RD_LSB  = 2;
   localparam int IMM_W   = 11;

   // Opcodes and opcode classes
   localparam logic [4:0] OP_HALT  = 5'b00000;
   localparam logic [4:0] OP_NOP   = 5'b00001;
   localparam logic [2:0] CLS_JUMP = 3'b001;
   localparam logic [2:0] CLS_ADDI = 3'b010;
   localparam logic [1:0] CLS_ALU  = 2'b11;

   //////////////////////////////////////////////////
   // Decode helpers
   //////////////////////////////////////////////////
   function automatic logic is_halt(instr_t w);
      return w[OPC_MSB -: 5] == OP_HALT;
   endfunction

   function automatic logic is_jump(instr_t w);
      return w[OPC_MSB -: 3] == CLS_JUMP;
   endfunction

   function automatic logic is_addi(instr_t w);
      return w[OPC_MSB -: 3] == CLS_ADDI;
   endfunction

   function automatic logic is_alu(instr_t w);
      return w[OPC_MSB -: 2] == CLS_ALU;
   endfunction

   // Both classes read rs, only ALU reads rt
   function automatic logic uses_rs(instr_t w);
      return is_addi(w) || is_alu(w);
   endfunction

   function automatic logic uses_rt(instr_t w);
      return is_alu(w);
   endfunction

   function automatic logic writes_dst(instr_t w);
      return is_addi(w) || is_alu(w);
   endfunction

   // ADDI writes rt, ALU writes rd
   function automatic reg_idx_t dst_of(instr_t w);
      return is_addi(w) ? w[RT_LSB +: 3] : w[RD_LSB +: 3];
   endfunction

   // pc + 2 + 2 * sext(imm11)
   function automatic pc_t jump_target(pc_t pc, instr_t w);
      pc_t offs;
      offs = {{(16 - IMM_W - 1){w[IMM_W-1]}}, w[IMM_W-1:0], 1'b0};
      return pc + 16'd2 + offs;
   endfunction

endpackage

`default_nettype wire

//--- fetch_ifs.sv
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////
// Instruction memory bus
//////////////////////////////////////////////////
interface imem_if;

   // Read side, byte address in, word out same cycle
   fetch_pkg::pc_t    rd_addr;
   fetch_pkg::instr_t rd_data;

   // Load side, driven from top level load ports
   logic              wr_en;
   fetch_pkg::pc_t    wr_addr;
   fetch_pkg::instr_t wr_data;

   modport fetch (
      output rd_addr,
      input  rd_data
   );

   modport rom (
      input  rd_addr,
      output rd_data
   );

   // Memory view of the load side
   modport loader (
      input  wr_en,
      input  wr_addr,
      input  wr_data
   );

endinterface

//////////////////////////////////////////////////
// Fetch to RAW detector
//////////////////////////////////////////////////
interface hazard_if;

   // Sources of the word at the current pc
   fetch_pkg::reg_idx_t src1;
   logic                src1_v;
   fetch_pkg::reg_idx_t src2;
   logic                src2_v;

   // Issue strobe plus destination of that word
   logic                issue;
   fetch_pkg::reg_idx_t dst;
   logic                dst_v;

   // Conflict flag back to fetch
   logic                raw;

   modport fetch (
      output src1, src1_v, src2, src2_v,
      output issue, dst, dst_v,
      input  raw
   );

   modport det (
      input  src1, src1_v, src2, src2_v,
      input  issue, dst, dst_v,
      output raw
   );

endinterface

`default_nettype wire

//--- instr_rom.sv
`timescale 1ns/1ps
`default_nettype none

module instr_rom #(
   parameter int IMEM_WORDS = 64
) (
   input  wire    clk,
   imem_if.rom    rom,
   imem_if.loader loader
);

   // Index width, at least one bit
   localparam int AW = (IMEM_WORDS > 1) ? $clog2(IMEM_WORDS) : 1;

   fetch_pkg::instr_t mem [IMEM_WORDS];

   // Word index is the byte address without bit 0
   logic [14:0] rd_idx;
   logic [14:0] wr_idx;

   assign rd_idx = rom.rd_addr[15:1];
   assign wr_idx = loader.wr_addr[15:1];

   // Async read, past the end reads as halt
   always_comb begin
      if (rd_idx < 15'(IMEM_WORDS)) begin
         rom.rd_data = mem[rd_idx[AW-1:0]];
      end else begin
         rom.rd_data = {fetch_pkg::OP_HALT, 11'b0};
      end
   end

   // Load port write
   always_ff @(posedge clk) begin
      if (loader.wr_en && (wr_idx < 15'(IMEM_WORDS))) begin
         mem[wr_idx[AW-1:0]] <= loader.wr_data;
      end
   end

   // Loader must stay inside the array
   a_wr_in_range: assert property (@(posedge clk)
      loader.wr_en |-> (wr_idx < 15'(IMEM_WORDS)));

endmodule

`default_nettype wire

//--- raw_detector.sv
`timescale 1ns/1ps
`default_nettype none

module raw_detector #(
   parameter int HAZARD_DEPTH = 3
) (
   input  wire   clk,
   input  wire   rst_n,
   hazard_if.det hz
);

   //////////////////////////////////////////////////
   // In-flight destination window
   //////////////////////////////////////////////////
   // Entry 0 is the newest issue
   fetch_pkg::reg_idx_t     win_dst [HAZARD_DEPTH];
   logic [HAZARD_DEPTH-1:0] win_v;

   // Valid bits, shift every clock
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         win_v <= '0;
      end else begin
         // Head only valid for a register writer
         win_v[0] <= hz.issue && hz.dst_v;
         for (int i = 1; i < HAZARD_DEPTH; i++) begin
            win_v[i] <= win_v[i-1];
         end
      end
   end

   // Index payload follows the valid bits
   always_ff @(posedge clk) begin
      win_dst[0] <= hz.dst;
      for (int i = 1; i < HAZARD_DEPTH; i++) begin
         win_dst[i] <= win_dst[i-1];
      end
   end

   //////////////////////////////////////////////////
   // Source compare
   //////////////////////////////////////////////////
   logic [HAZARD_DEPTH-1:0] hit;

   always_comb begin
      for (int i = 0; i < HAZARD_DEPTH; i++) begin
         // Match against either live source
         hit[i] = win_v[i] &&
                  ((hz.src1_v && (hz.src1 == win_dst[i])) ||
                   (hz.src2_v && (hz.src2 == win_dst[i])));
      end
   end

   // Any hit stalls the current word
   assign hz.raw = |hit;

   // Fetch must never issue into a live conflict
   a_no_issue_on_raw: assert property (@(posedge clk) disable iff (!rst_n)
      hz.issue |-> !hz.raw);

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter int CREDITS    = 4,
   parameter int DUMP_DELAY = 5
) (
   input  wire                 clk,
   input  wire                 rst_n,
   imem_if.fetch               imem,
   hazard_if.fetch             hz,
   input  wire                 credit_return,
   input  wire                 redirect_valid,
   input  wire fetch_pkg::pc_t redirect_pc,
   output logic                issue_valid,
   output fetch_pkg::pc_t      issue_pc,
   output fetch_pkg::instr_t   issue_instr,
   output logic                dump
);

   // Credit and dump counter widths
   localparam int CW = $clog2(CREDITS + 1);
   localparam int DW = (DUMP_DELAY > 1) ? $clog2(DUMP_DELAY) : 1;

   fetch_pkg::pc_t    pc;
   fetch_pkg::instr_t word;
   logic [CW-1:0]     credits;
   logic              jmp_wait;
   logic              halted;
   logic [DW-1:0]     dump_cnt;
   logic              take;

   //////////////////////////////////////////////////
   // Fetch and decode
   //////////////////////////////////////////////////
   assign imem.rd_addr = pc;
   assign word         = imem.rd_data;

   // Sources to the RAW detector
   assign hz.src1   = word[fetch_pkg::RS_LSB +: 3];
   assign hz.src1_v = fetch_pkg::uses_rs(word);
   assign hz.src2   = word[fetch_pkg::RT_LSB +: 3];
   assign hz.src2_v = fetch_pkg::uses_rt(word);

   // Issue when credit left, no hazard, not stalled
   assign take = (credits != '0) && !hz.raw && !jmp_wait && !halted;

   assign hz.issue = take;
   assign hz.dst   = fetch_pkg::dst_of(word);
   assign hz.dst_v = fetch_pkg::writes_dst(word);

   //////////////////////////////////////////////////
   // Program counter
   //////////////////////////////////////////////////
   // Redirect from execute wins over sequential advance
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (redirect_valid) begin
         pc <= redirect_pc;
      end else if (take) begin
         pc <= pc + 16'd2;
      end
   end

   // Credits: one out per issue, one back per return
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= CW'(CREDITS);
      end else begin
         case ({take, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Jump wait, halt and dump timing
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         jmp_wait <= 1'b0;
         halted   <= 1'b0;
         dump_cnt <= '0;
         dump     <= 1'b0;
      end else begin
         // Hold off until execute resolves the jump
         if (redirect_valid) begin
            jmp_wait <= 1'b0;
         end else if (take && fetch_pkg::is_jump(word)) begin
            jmp_wait <= 1'b1;
         end
         // Halt issue arms the countdown
         if (take && fetch_pkg::is_halt(word)) begin
            halted   <= 1'b1;
            dump_cnt <= DW'(DUMP_DELAY - 1);
         end else if (halted && !dump) begin
            if (dump_cnt == '0) begin
               dump <= 1'b1;
            end else begin
               dump_cnt <= dump_cnt - 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Issue register
   //////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= take;
      end
   end

   // Payload only moves on issue
   always_ff @(posedge clk) begin
      if (take) begin
         issue_pc    <= pc;
         issue_instr <= word;
      end
   end

   // Back end returns no more than it was given
   a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      (credit_return && !take) |-> (credits < CW'(CREDITS)));

endmodule

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
   parameter int IMEM_WORDS   = 64,
   parameter int CREDITS      = 4,
   parameter int HAZARD_DEPTH = 3,
   parameter int DUMP_DELAY   = 5
) (
   input  wire                    clk,
   input  wire                    rst_n,
   // Program load
   input  wire                    load_en,
   input  wire fetch_pkg::pc_t    load_addr,
   input  wire fetch_pkg::instr_t load_data,
   // Back end and execute
   input  wire                    credit_return,
   input  wire                    redirect_valid,
   input  wire fetch_pkg::pc_t    redirect_pc,
   // Issue to next stage
   output logic                   issue_valid,
   output fetch_pkg::pc_t         issue_pc,
   output fetch_pkg::instr_t      issue_instr,
   output logic                   dump
);

   imem_if   imem ();
   hazard_if hz ();

   // Load ports onto the memory bus
   assign imem.wr_en   = load_en;
   assign imem.wr_addr = load_addr;
   assign imem.wr_data = load_data;

   instr_rom #(
      .IMEM_WORDS (IMEM_WORDS)
   ) u_rom (
      .clk    (clk),
      .rom    (imem),
      .loader (imem)
   );

   raw_detector #(
      .HAZARD_DEPTH (HAZARD_DEPTH)
   ) u_raw (
      .clk   (clk),
      .rst_n (rst_n),
      .hz    (hz)
   );

   fetch_stage #(
      .CREDITS    (CREDITS),
      .DUMP_DELAY (DUMP_DELAY)
   ) u_fetch (
      .clk            (clk),
      .rst_n          (rst_n),
      .imem           (imem),
      .hz             (hz),
      .credit_return  (credit_return),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .issue_valid    (issue_valid),
      .issue_pc       (issue_pc),
      .issue_instr    (issue_instr),
      .dump           (dump)
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free running clock plus power-on reset
module tb_clock_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial clk = 1'b0;
   always #(PERIOD / 2) clk = ~clk;

   // Release on a falling edge, away from DUT sampling
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

   // Same values as the DUT defaults
   localparam int CREDITS      = 4;
   localparam int HAZARD_DEPTH = 3;
   localparam int DUMP_DELAY   = 5;
   localparam int RESET_CYCLES = 16;

   logic clk;
   logic gen_rst_n;
   logic tb_rst_n;
   logic rst_n;
   logic load_en;
   fetch_pkg::pc_t    load_addr;
   fetch_pkg::instr_t load_data;
   logic credit_return;
   logic redirect_valid;
   fetch_pkg::pc_t    redirect_pc;
   logic issue_valid;
   fetch_pkg::pc_t    issue_pc;
   fetch_pkg::instr_t issue_instr;
   logic dump;

   // Power-on reset and per-test reset combined
   assign rst_n = gen_rst_n & tb_rst_n;

   string  cur_name;
   int     errors = 0;
   int     test_errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     failed_tests = 0;
   longint cycles = 0;
   longint limit = 2 * RESET_CYCLES;

   // Current test, filled from the cases file
   fetch_pkg::instr_t prog [$];
   fetch_pkg::pc_t    exp_pc [$];
   fetch_pkg::instr_t exp_w [$];
   int                due [$];

   tb_clock_gen #(.PERIOD(20), .RST_CYCLES(RESET_CYCLES)) u_clk (
      .clk   (clk),
      .rst_n (gen_rst_n)
   );

   fetch_top dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .load_en        (load_en),
      .load_addr      (load_addr),
      .load_data      (load_data),
      .credit_return  (credit_return),
      .redirect_valid (redirect_valid),
      .redirect_pc    (redirect_pc),
      .issue_valid    (issue_valid),
      .issue_pc       (issue_pc),
      .issue_instr    (issue_instr),
      .dump           (dump)
   );

   //////////////////////////////////////////////////
   // Watchdog
   //////////////////////////////////////////////////
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Run stopped: cycle limit of %0d reached", limit);
         $display("TB FAILED");
         $finish;
      end
   end

   task automatic check_value(string what, logic [31:0] exp_v, logic [31:0] act_v);
      checks++;
      if (exp_v !== act_v) begin
         errors++;
         test_errors++;
         $display("** Error %s %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
      end
   endtask

   task automatic report_failure(string msg);
      errors++;
      test_errors++;
      $display("%s: %s", cur_name, msg);
   endtask

   // Program load while reset is held, then release
   task automatic load_and_reset();
      int n;
      @(negedge clk);
      tb_rst_n       = 1'b0;
      credit_return  = 1'b0;
      redirect_valid = 1'b0;
      n = 0;
      foreach (prog[i]) begin
         load_en   = 1'b1;
         load_addr = fetch_pkg::pc_t'(i * 2);
         load_data = prog[i];
         @(negedge clk);
         n++;
      end
      load_en = 1'b0;
      while (n < RESET_CYCLES || !gen_rst_n) begin
         @(negedge clk);
         n++;
      end
      tb_rst_n = 1'b1;
      check_value("issue_valid after reset", 0, issue_valid);
      check_value("dump after reset", 0, dump);
   endtask

   //////////////////////////////////////////////////
   // One test: play back end and execute
   //////////////////////////////////////////////////
   task automatic run_test(int dmin, int dmax, int hold, int abort);
      int k;
      int idx;
      int issued;
      int returned;
      int ret_last;
      int ret_avail;
      int ready_k;
      int jump_k;
      int halt_k;
      int last_wr [8];
      logic jump_pend;
      logic redirected;
      logic done;
      logic can_issue;
      fetch_pkg::pc_t    tgt;
      fetch_pkg::instr_t w;
      fetch_pkg::instr_t nw;
      k = 0;
      idx = 0;
      issued = 0;
      returned = 0;
      ret_last = 0;
      ret_avail = 0;
      ready_k = 1;
      jump_k = -1;
      halt_k = -1;
      jump_pend = 1'b0;
      redirected = 1'b0;
      done = 1'b0;
      tgt = '0;
      foreach (last_wr[r]) last_wr[r] = -100;
      due.delete();
      load_and_reset();
      while (!done) begin
         @(negedge clk);
         k++;
         // Returns driven two negedges back are usable now
         ret_avail = ret_last;
         ret_last  = returned;
         // Sample first, outputs settled since the rising edge
         if (issue_valid) begin
            w = issue_instr;
            if (jump_pend) report_failure("issue while waiting for a jump redirect");
            if (idx >= exp_pc.size()) begin
               report_failure("issue beyond the expected stream");
            end else begin
               check_value("pc", exp_pc[idx], issue_pc);
               check_value("word", exp_w[idx], w);
            end
            if (redirected) begin
               check_value("jump target pc", tgt, issue_pc);
               redirected = 1'b0;
            end
            // Dependent words wait out the window
            if (fetch_pkg::uses_rs(w) && (k - last_wr[w[10:8]] < HAZARD_DEPTH + 1))
               report_failure("rs read inside the hazard window");
            if (fetch_pkg::uses_rt(w) && (k - last_wr[w[7:5]] < HAZARD_DEPTH + 1))
               report_failure("rt read inside the hazard window");
            if (fetch_pkg::writes_dst(w)) last_wr[fetch_pkg::dst_of(w)] = k;
            ready_k = k + 1;
            if (fetch_pkg::is_jump(w)) begin
               jump_pend = 1'b1;
               jump_k = k;
               tgt = fetch_pkg::jump_target(issue_pc, w);
               // Redirect two cycles on, target issues two after that
               ready_k = k + 4;
            end
            if (fetch_pkg::is_halt(w)) halt_k = k;
            due.push_back(k + dmin + int'($urandom % (dmax - dmin + 1)));
            issued++;
            idx++;
            if (abort > 0 && idx == abort) done = 1'b1;
         end
         // Free word with credit left must not stall
         if (!issue_valid && idx < exp_w.size() && k >= ready_k &&
             (issued - ret_avail < CREDITS)) begin
            nw = exp_w[idx];
            can_issue = 1'b1;
            if (fetch_pkg::uses_rs(nw) && (k - last_wr[nw[10:8]] < HAZARD_DEPTH + 1))
               can_issue = 1'b0;
            if (fetch_pkg::uses_rt(nw) && (k - last_wr[nw[7:5]] < HAZARD_DEPTH + 1))
               can_issue = 1'b0;
            if (can_issue) report_failure("independent word held back");
         end
         if (dump && !done) begin
            if (halt_k < 0) report_failure("dump rose without a halt issue");
            else check_value("dump delay", DUMP_DELAY, k - halt_k);
            check_value("issue count", exp_pc.size(), idx);
            done = 1'b1;
         end
         // Then drive for the next rising edge
         credit_return  = 1'b0;
         redirect_valid = 1'b0;
         if (due.size() > 0 && due[0] <= k && k > hold) begin
            credit_return = 1'b1;
            void'(due.pop_front());
            returned++;
         end
         if (issued - returned > CREDITS) report_failure("more issues outstanding than credits");
         if (jump_pend && k == jump_k + 2) begin
            redirect_valid = 1'b1;
            redirect_pc    = tgt;
            jump_pend      = 1'b0;
            redirected     = 1'b1;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Cases file reader and summary
   //////////////////////////////////////////////////
   initial begin
      int fd;
      int n;
      int dmin;
      int dmax;
      int hold;
      int abort;
      string line;
      string tok;
      string name;
      logic [15:0] a;
      logic [15:0] b;
      void'($urandom(32'he242));
      tb_rst_n = 1'b0;
      load_en = 1'b0;
      load_addr = '0;
      load_data = '0;
      credit_return = 1'b0;
      redirect_valid = 1'b0;
      redirect_pc = '0;
      fd = $fopen("fetch_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open fetch_cases.txt");
         $display("TB FAILED");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s", tok) == 1) begin
               if (tok == "test") begin
                  n = $sscanf(line, "test %s %d %d %d %d", name, dmin, dmax, hold, abort);
                  cur_name = name;
                  prog.delete();
                  exp_pc.delete();
                  exp_w.delete();
               end else if (tok == "w") begin
                  n = $sscanf(line, "w %h", a);
                  prog.push_back(a);
               end else if (tok == "x") begin
                  n = $sscanf(line, "x %h %h", a, b);
                  exp_pc.push_back(a);
                  exp_w.push_back(b);
               end else if (tok == "end") begin
                  limit += 2 * (exp_pc.size() * (HAZARD_DEPTH + dmax + hold + 4)
                                + DUMP_DELAY + RESET_CYCLES);
                  test_errors = 0;
                  run_test(dmin, dmax, hold, abort);
                  tests++;
                  if (test_errors != 0) failed_tests++;
                  $display("test %s: %s", cur_name, (test_errors == 0) ? "ok" : "errors");
               end
            end
         end
         $fclose(fd);
         $display("tests %0d, failed %0d, checks %0d, errors %0d",
                  tests, failed_tests, checks, errors);
         if (errors == 0 && tests > 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- fetch_cases.txt
# test <name> <credit delay min> <max> <withhold cycles> <abort after n issues, 0 = run to dump>
# w <word> loads the next word from pc 0; x <pc> <word> is the next expected issue
test straight 1 3 0 0
w 4140
w 0800
w 4380
w 0000
x 0 4140
x 2 0800
x 4 4380
x 6 0000
end
test backpressure 2 4 12 0
w 0800
w 0800
w 0800
w 0800
w 0800
w 0800
w 0000
x 0 0800
x 2 0800
x 4 0800
x 6 0800
x 8 0800
x a 0800
x c 0000
end
test hazard 1 1 0 0
w 4140
w 0800
w c274
w 0000
x 0 4140
x 2 0800
x 4 c274
x 6 0000
end
test jump 1 2 0 0
w 0800
w 2002
w 0000
w 0000
w 4140
w 0000
x 0 0800
x 2 2002
x 8 4140
x a 0000
end
test reset_mid 1 2 0 3
w 0800
w 0800
w 0800
w 0800
w 0800
w 0000
x 0 0800
x 2 0800
x 4 0800
end
test after_reset 5 5 0 0
w 0800
w 0800
w 0800
w 0800
w 0800
w 0000
x 0 0800
x 2 0800
x 4 0800
x 6 0800
x 8 0800
x a 0000
end

//--- flist.f
fetch_pkg.sv
fetch_ifs.sv
instr_rom.sv
raw_detector.sv
fetch_stage.sv
fetch_top.sv
tb_clock_gen.sv
fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
